// File: Bender.yml
package:
  name: code_lock

sources:
  - include_dirs:
      - src
    files:
      - src/code_lock_pkg.sv
      - src/button_debouncer.sv
      - src/lock_fsm.sv
      - src/segment_driver.sv
      - src/code_lock_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verif/code_lock_tb.sv

// File: code_lock.f
+incdir+src
src/code_lock_pkg.sv
src/button_debouncer.sv
src/lock_fsm.sv
src/segment_driver.sv
src/code_lock_top.sv
verif/code_lock_tb.sv

// File: src/button_debouncer.sv
`timescale 1ns/1ps
`include "code_lock_settings.svh"

module button_debouncer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [3:0]                btn,
  output code_lock_pkg::btn_event_t press
);

  localparam int CNT_W = $clog2(`CODE_LOCK_DEBOUNCE_CYCLES + 1);

  logic [3:0]       btn_q;     // Last sampled pattern
  logic [CNT_W-1:0] cnt;
  logic             armed;     // Set once all buttons are up
  logic             same;
  logic             one_hot;
  logic             fire;
  logic [1:0]       idx;

  assign same    = (btn == btn_q);
  assign one_hot = (btn != 4'b0000) && ((btn & (btn - 4'd1)) == 4'b0000);

  // Count reaches the limit on this cycle
  assign fire = same && one_hot && armed &&
                (cnt == CNT_W'(`CODE_LOCK_DEBOUNCE_CYCLES - 1));

  always_comb begin
    case (btn_q)
      4'b0010: idx = 2'd1;
      4'b0100: idx = 2'd2;
      4'b1000: idx = 2'd3;
      default: idx = 2'd0;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      btn_q <= 4'b0000;
      cnt   <= '0;
      armed <= 1'b1;
      press <= '0;
    end else begin
      btn_q <= btn;
      if (!(same && one_hot)) begin
        cnt <= '0;                                  // Restart on any change
      end else if (cnt != CNT_W'(`CODE_LOCK_DEBOUNCE_CYCLES)) begin
        cnt <= cnt + 1'b1;                          // Saturate at the limit
      end

      if (btn == 4'b0000) begin
        armed <= 1'b1;
      end else if (fire) begin
        armed <= 1'b0;                              // Held button fires once
      end

      press.valid <= fire;
      press.idx   <= idx;
    end
  end

  strobe_one_cycle: assert property (@(posedge clk) disable iff (!rst)
    press.valid |=> !press.valid);

endmodule

// File: src/code_lock_pkg.sv
`include "code_lock_settings.svh"

package code_lock_pkg;

  // Wide enough to hold 0 up to the full code length
  localparam int PROGRESS_W = $clog2(`CODE_LOCK_STEPS + 1);

  typedef enum logic [1:0] {
    ST_LOCKED,
    ST_OPEN,
    ST_VIEW
  } lock_state_e;

  // Display opcode
  typedef enum logic [1:0] {
    GLYPH_HEX,   // Nibble as hex digit
    GLYPH_L,
    GLYPH_P,
    GLYPH_BLANK
  } glyph_e;

  // One-cycle press strobe from the debouncer
  typedef struct packed {
    logic       valid;
    logic [1:0] idx;   // Button number
  } btn_event_t;

  // Display request, held until the next press
  typedef struct packed {
    glyph_e                  glyph;
    logic [1:0]              digit;
    logic [3:0]              value;
    logic [PROGRESS_W-1:0]   progress;
  } disp_req_t;

endpackage

// File: src/code_lock_settings.svh
`ifndef CODE_LOCK_SETTINGS_SVH
`define CODE_LOCK_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Debounce and code
////////////////////////////////////////////////////////////////////////////

`define CODE_LOCK_DEBOUNCE_CYCLES 4   // Short for simulation, raise on board

`define CODE_LOCK_STEPS 4             // Code length in presses

`define CODE_LOCK_DIGIT0 4'h2         // Step 0, button 3
`define CODE_LOCK_DIGIT1 4'h8         // Step 1, button 2
`define CODE_LOCK_DIGIT2 4'h9         // Step 2, button 1
`define CODE_LOCK_DIGIT3 4'h5         // Step 3, button 0

////////////////////////////////////////////////////////////////////////////
// Board widths
////////////////////////////////////////////////////////////////////////////

`define CODE_LOCK_LED_W 8

`endif

// File: src/code_lock_top.sv
`timescale 1ns/1ps
`include "code_lock_settings.svh"

module code_lock_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [3:0]                   btn,
  input  logic [3:0]                   switches,
  input  logic                         dip,
  output logic [`CODE_LOCK_LED_W-1:0]  led,
  output logic [6:0]                   cathodes,
  output logic [3:0]                   anode
);

  code_lock_pkg::btn_event_t press;   // Debounced strobe
  code_lock_pkg::disp_req_t  req;     // Held display request

  button_debouncer debouncer_i (
    .clk   (clk),
    .rst   (rst),
    .btn   (btn),
    .press (press)
  );

  lock_fsm fsm_i (
    .clk      (clk),
    .rst      (rst),
    .press    (press),
    .switches (switches),
    .dip      (dip),
    .req      (req)
  );

  segment_driver display_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .cathodes (cathodes),
    .anode    (anode),
    .led      (led)
  );

endmodule

// File: src/lock_fsm.sv
`timescale 1ns/1ps
`include "code_lock_settings.svh"

module lock_fsm (
  input  logic                      clk,
  input  logic                      rst,
  input  code_lock_pkg::btn_event_t press,
  input  logic [3:0]                switches,
  input  logic                      dip,
  output code_lock_pkg::disp_req_t  req
);

  localparam int PW   = code_lock_pkg::PROGRESS_W;
  localparam int LAST = `CODE_LOCK_STEPS - 1;

  code_lock_pkg::lock_state_e state, state_d;
  code_lock_pkg::disp_req_t   req_d;
  logic [PW-1:0]              progress, progress_d;
  logic [3:0]                 exp_nibble;
  logic [1:0]                 exp_btn;
  logic                       step_ok;

  // Entry runs from button 3 down to button 0
  assign exp_btn = 2'(LAST) - progress[1:0];

  always_comb begin
    case (progress)
      PW'(0):  exp_nibble = `CODE_LOCK_DIGIT0;
      PW'(1):  exp_nibble = `CODE_LOCK_DIGIT1;
      PW'(2):  exp_nibble = `CODE_LOCK_DIGIT2;
      PW'(3):  exp_nibble = `CODE_LOCK_DIGIT3;
      default: exp_nibble = 4'h0;
    endcase
  end

  assign step_ok = (press.idx == exp_btn) && (switches == exp_nibble);

  ////////////////////////////////////////////////////////////////////////////
  // Next state, evaluated only on a press
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state;
    progress_d = progress;
    req_d      = req;
    if (press.valid) begin
      case (state)
        code_lock_pkg::ST_LOCKED: begin
          if (dip) begin
            if (step_ok && progress == PW'(LAST)) begin
              state_d    = code_lock_pkg::ST_OPEN;
              progress_d = PW'(`CODE_LOCK_STEPS);
            end else if (step_ok) begin
              progress_d = progress + 1'b1;
            end else begin
              progress_d = '0;                      // Wrong button or nibble
            end
          end
        end
        code_lock_pkg::ST_OPEN,
        code_lock_pkg::ST_VIEW: begin
          if (dip) begin
            state_d    = code_lock_pkg::ST_LOCKED;   // Relock
            progress_d = '0;
          end else begin
            state_d = code_lock_pkg::ST_VIEW;
          end
        end
        default: begin
          state_d    = code_lock_pkg::ST_LOCKED;
          progress_d = '0;
        end
      endcase

      req_d.progress = progress_d;
      case (state_d)
        code_lock_pkg::ST_VIEW: begin
          req_d.glyph = code_lock_pkg::GLYPH_HEX;
          req_d.digit = press.idx;
          req_d.value = switches;                  // Captured, not tracked
        end
        code_lock_pkg::ST_OPEN: begin
          req_d.glyph = code_lock_pkg::GLYPH_P;
          req_d.digit = 2'd0;
          req_d.value = 4'h0;
        end
        default: begin
          req_d.glyph = code_lock_pkg::GLYPH_L;
          req_d.digit = 2'd0;
          req_d.value = 4'h0;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state        <= code_lock_pkg::ST_LOCKED;
      progress     <= '0;
      req.glyph    <= code_lock_pkg::GLYPH_L;
      req.digit    <= 2'd0;
      req.value    <= 4'h0;
      req.progress <= '0;
    end else begin
      state    <= state_d;
      progress <= progress_d;
      req      <= req_d;
    end
  end

  progress_bound: assert property (@(posedge clk) disable iff (!rst)
    progress <= PW'(`CODE_LOCK_STEPS));

endmodule

// File: src/segment_driver.sv
`timescale 1ns/1ps
`include "code_lock_settings.svh"

module segment_driver (
  input  logic                         clk,
  input  logic                         rst,
  input  code_lock_pkg::disp_req_t     req,
  output logic [6:0]                   cathodes,
  output logic [3:0]                   anode,
  output logic [`CODE_LOCK_LED_W-1:0]  led
);

  localparam int LED_W = `CODE_LOCK_LED_W;

  // Active low, bit order g..a
  localparam logic [6:0] SEG_L     = 7'b1000111;
  localparam logic [6:0] SEG_P     = 7'b0001100;
  localparam logic [6:0] SEG_BLANK = 7'b1111111;

  logic [6:0]       hex_seg;
  logic [6:0]       seg_d;
  logic [3:0]       an_d;
  logic [LED_W-1:0] led_d;

  always_comb begin
    case (req.value)
      4'h0: hex_seg = 7'b1000000;
      4'h1: hex_seg = 7'b1111001;
      4'h2: hex_seg = 7'b0100100;
      4'h3: hex_seg = 7'b0110000;
      4'h4: hex_seg = 7'b0011001;
      4'h5: hex_seg = 7'b0010010;
      4'h6: hex_seg = 7'b0000010;
      4'h7: hex_seg = 7'b1111000;
      4'h8: hex_seg = 7'b0000000;
      4'h9: hex_seg = 7'b0010000;
      4'hA: hex_seg = 7'b0001000;
      4'hB: hex_seg = 7'b0000011;   // Lower case b
      4'hC: hex_seg = 7'b1000110;
      4'hD: hex_seg = 7'b0100001;   // Lower case d
      4'hE: hex_seg = 7'b0000110;
      default: hex_seg = 7'b0001110;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Glyph select and LED bar
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    an_d = ~(4'b0001 << req.digit);                 // One digit lit
    case (req.glyph)
      code_lock_pkg::GLYPH_HEX: begin
        seg_d = hex_seg;
        led_d = '0;
      end
      code_lock_pkg::GLYPH_L: begin
        seg_d = SEG_L;
        led_d = (LED_W'(1) << req.progress) - LED_W'(1);   // Thermometer
      end
      code_lock_pkg::GLYPH_P: begin
        seg_d = SEG_P;
        led_d = '1;
      end
      default: begin
        seg_d = SEG_BLANK;
        led_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cathodes <= SEG_L;
      anode    <= 4'b1110;
      led      <= '0;
    end else begin
      cathodes <= seg_d;
      anode    <= an_d;
      led      <= led_d;
    end
  end

  single_digit: assert property (@(posedge clk) disable iff (!rst)
    $onehot0(~anode));

endmodule

// File: verif/code_lock_tb.sv
`timescale 1ns/1ps
`include "code_lock_settings.svh"

module code_lock_tb;

  localparam int HOLD      = `CODE_LOCK_DEBOUNCE_CYCLES + 6;
  localparam int RELEASE   = `CODE_LOCK_DEBOUNCE_CYCLES + 2;
  localparam int BOUNCE_ON = (`CODE_LOCK_DEBOUNCE_CYCLES > 2) ?
                             `CODE_LOCK_DEBOUNCE_CYCLES - 2 : 1;
  localparam int RESET_TIMEOUT = 10;

  logic                        clk;
  logic                        rst;
  logic [3:0]                  btn;
  logic [3:0]                  switches;
  logic                        dip;
  logic [`CODE_LOCK_LED_W-1:0] led;
  logic [6:0]                  cathodes;
  logic [3:0]                  anode;

  int          value_errs;
  int          strobe_errs;
  int          timeout_errs;
  int          strobes;
  int          line_no;
  int unsigned seed;

  code_lock_top dut_i (
    .clk      (clk),
    .rst      (rst),
    .btn      (btn),
    .switches (switches),
    .dip      (dip),
    .led      (led),
    .cathodes (cathodes),
    .anode    (anode)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Sample mid-cycle, return on the next rising edge
  task sample_cycle();
    @(negedge clk);
    if (dut_i.press.valid) strobes++;
    @(posedge clk);
  endtask

  task check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
    assert (got === exp) else begin
      $display("ERR %s exp %h got %h (line %0d)", name, exp, got, line_no);
      value_errs++;
    end
  endtask

  task apply_press(input int idx);
    strobes = 0;
    btn <= 4'b0001 << idx;
    for (int i = 0; i < HOLD; i++) sample_cycle();
    assert (strobes > 0) else begin
      $display("No press strobe within the hold time (line %0d)", line_no);
      timeout_errs++;
    end
    btn <= 4'b0000;
    for (int i = 0; i < RELEASE; i++) sample_cycle();
  endtask

  // Pulses shorter than the debounce window
  task apply_bounce();
    strobes = 0;
    for (int r = 0; r < 4; r++) begin
      btn <= 4'b1000;
      for (int i = 0; i < BOUNCE_ON; i++) sample_cycle();
      btn <= 4'b0000;
      sample_cycle();
    end
    for (int i = 0; i < RELEASE; i++) sample_cycle();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int           fd;
    int           n_fields;
    int           n_lines;
    int           wait_cnt;
    int           f_idx;
    logic         f_dip;
    logic [3:0]   f_sw;
    logic [7:0]   exp_an;
    logic [7:0]   exp_cat;
    logic [7:0]   exp_led;
    reg [8*128-1:0] line_buf;

    value_errs   = 0;
    strobe_errs  = 0;
    timeout_errs = 0;
    n_lines      = 0;
    line_no      = 0;
    seed         = 32'ha638_153c;
    void'($urandom(seed));
    rst      = 1'b0;
    btn      = 4'b0000;
    switches = 4'h0;
    dip      = 1'b0;

    repeat (3) @(posedge clk);
    rst <= 1'b1;
    wait_cnt = 0;
    while (anode !== 4'he && wait_cnt < RESET_TIMEOUT) begin
      @(posedge clk);
      wait_cnt++;
    end
    assert (anode === 4'he) else begin
      $display("Display did not settle after reset");
      timeout_errs++;
    end
    @(posedge clk);

    fd = $fopen("verif/code_lock_testdata.txt", "r");
    assert (fd != 0) else begin
      $display("Cannot open the test data file");
      timeout_errs++;
    end
    if (fd != 0) begin
      while ($fgets(line_buf, fd) != 0) begin
        line_no++;
        n_fields = $sscanf(line_buf, "%d %h %h %h %h %h",
                           f_idx, f_dip, f_sw, exp_an, exp_cat, exp_led);
        if (n_fields == 6) begin
          n_lines++;
          repeat ($urandom % 8) sample_cycle();    // Idle gap
          dip      <= f_dip;
          switches <= f_sw;
          if (f_idx == 4) apply_bounce();
          else apply_press(f_idx);
          assert (strobes == ((f_idx == 4) ? 0 : 1)) else begin
            $display("ERR press.valid count exp %h got %h (line %0d)",
                     (f_idx == 4) ? 0 : 1, strobes, line_no);
            strobe_errs++;
          end
          @(negedge clk);
          check_value("anode", exp_an, {4'h0, anode});
          check_value("cathodes", exp_cat, {1'b0, cathodes});
          check_value("led", exp_led, led);
          @(posedge clk);
        end
      end
      $fclose(fd);
    end
    assert (n_lines > 0) else begin
      $display("No test lines were read");
      timeout_errs++;
    end

    $display("Lines %0d, value errors %0d, strobe errors %0d, timeouts %0d",
             n_lines, value_errs, strobe_errs, timeout_errs);
    if (value_errs + strobe_errs + timeout_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verif/code_lock_testdata.txt
# btn dip switches | expected anode cathodes led, all hex
# btn 4 is a bounce line that must leave the outputs unchanged
4 1 2 e 47 00
0 0 a e 47 00
2 0 f e 47 00
3 1 2 e 47 01
2 1 8 e 47 03
1 1 9 e 47 07
0 1 4 e 47 00
3 1 2 e 47 01
1 1 8 e 47 00
3 1 2 e 47 01
2 1 8 e 47 03
4 1 9 e 47 03
1 1 9 e 47 07
0 1 5 e 0c ff
0 0 a e 08 00
1 0 f d 0e 00
2 0 3 b 30 00
3 0 7 7 78 00
4 0 1 7 78 00
0 0 0 e 40 00
2 1 0 e 47 00
3 1 2 e 47 01
2 1 8 e 47 03
1 1 9 e 47 07
0 1 5 e 0c ff
1 1 2 e 47 00
